//--- common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// architectural register count, register 0 reads as zero
`define CPU_NUM_REGS 32

// pc step between sequential instructions
`define CPU_WORD_BYTES 32'd4

`endif

//--- common/cpu_types_pkg.sv
package cpu_types_pkg;

	// data, address and instruction words
	typedef logic [31:0] word_t;
	typedef logic [4:0] regbits_t;

	// major opcodes, values from the mips encoding
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// function field of register type instructions
	typedef enum logic [5:0] {
		JR   = 6'h08,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluop_t;

	typedef enum logic [1:0] {
		SEL_LOAD_NXT_INSTR,
		SEL_LOAD_BR_ADDR,
		SEL_LOAD_JMP_ADDR,
		SEL_LOAD_JR_ADDR
	} pcsel_t;

	// alu operand source
	typedef enum logic [1:0] {FWD_RF, FWD_EX_MEM, FWD_MEM_WB} fwdsel_t;

	typedef struct packed {
		word_t instr;
		word_t npc;
	} if_id_t;

	// an all zero payload is a bubble: no write, no memory request
	typedef struct packed {
		opcode_t opcode;
		aluop_t aluop;
		logic alu_src_imm;
		logic reg_wen;
		logic dren;
		logic dwen;
		logic halt;
		regbits_t rs;
		regbits_t rt;
		regbits_t rd;
		word_t rdat1;
		word_t rdat2;
		word_t imm;
		word_t br_addr;
		word_t npc;
	} id_ex_t;

	typedef struct packed {
		opcode_t opcode;
		logic zero;
		word_t result;
		word_t wdata;
		word_t br_addr;
		logic dren;
		logic dwen;
		regbits_t rd;
		logic reg_wen;
		logic halt;
	} ex_mem_t;

	typedef struct packed {
		word_t wb_val;
		regbits_t rd;
		logic reg_wen;
		logic halt;
	} mem_wb_t;

endpackage

//--- rtl/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic CLK,
	input logic rst,
	input logic en,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// flush only acts on a moving stage, a stalled one keeps its contents
	always_ff @(posedge CLK) begin
		if (rst) begin
			q <= '0;
		end else if (en) begin
			if (flush)
				q <= '0;
			else
				q <= d;
		end
	end

endmodule

//--- datapath/register_file.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module register_file (
	input logic CLK,
	input logic rst,
	input logic wen,
	input cpu_types_pkg::regbits_t wsel,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	input cpu_types_pkg::word_t wdat,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2
);
	import cpu_types_pkg::*;

	word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wen && wsel != '0) begin
			regs[wsel] <= wdat;
		end
	end

	// register 0 is hardwired
	// a same cycle write shows through to decode
	assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
	assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

//--- datapath/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit (
	input cpu_types_pkg::regbits_t rs_ID_EX,
	input cpu_types_pkg::regbits_t rt_ID_EX,
	input cpu_types_pkg::regbits_t rd_EX_MEM,
	input cpu_types_pkg::regbits_t rd_MEM_WB,
	input logic wen_EX_MEM,
	input logic wen_MEM_WB,
	output cpu_types_pkg::fwdsel_t fwd_a,
	output cpu_types_pkg::fwdsel_t fwd_b
);
	import cpu_types_pkg::*;

	// ex/mem holds the younger producer so it is checked first
	function automatic fwdsel_t pick_src(regbits_t src);
		if (src == '0)
			return FWD_RF;
		else if (wen_EX_MEM && rd_EX_MEM == src)
			return FWD_EX_MEM;
		else if (wen_MEM_WB && rd_MEM_WB == src)
			return FWD_MEM_WB;
		else
			return FWD_RF;
	endfunction

	assign fwd_a = pick_src(rs_ID_EX);
	assign fwd_b = pick_src(rt_ID_EX);

endmodule

//--- datapath/datapath.sv
`timescale 1ns/1ns

module datapath (
	input logic CLK,
	input logic rst,
	input cpu_types_pkg::word_t instr,
	input cpu_types_pkg::word_t npc,
	input cpu_types_pkg::word_t load_data,
	input logic enable_IF_ID,
	input logic enable_ID_EX,
	input logic enable_EX_MEM,
	input logic enable_MEM_WB,
	input logic flush_IF_ID,
	input logic flush_ID_EX,
	input logic flush_EX_MEM,
	input logic flush_MEM_WB,
	output cpu_types_pkg::opcode_t opcode_IF_ID,
	output cpu_types_pkg::opcode_t opcode_EX_MEM,
	output cpu_types_pkg::funct_t func_IF_ID,
	output cpu_types_pkg::regbits_t Rs_IF_ID,
	output cpu_types_pkg::regbits_t Rt_IF_ID,
	output cpu_types_pkg::regbits_t Rt_ID_EX,
	output logic dREN_ID_EX,
	output logic zero_EX_MEM,
	output cpu_types_pkg::word_t br_addr,
	output cpu_types_pkg::word_t jmp_addr,
	output cpu_types_pkg::word_t jr_addr,
	output cpu_types_pkg::word_t mem_addr,
	output cpu_types_pkg::word_t mem_wdata,
	output logic mem_ren,
	output logic mem_wen,
	output logic halt
);
	import cpu_types_pkg::*;

	if_id_t if_id_d, if_id_q;
	id_ex_t id_ex_d, id_ex_q;
	ex_mem_t ex_mem_d, ex_mem_q;
	mem_wb_t mem_wb_d, mem_wb_q;
	word_t ir, rdat1, rdat2, imm_sext, op_a, op_b, alu_b, alu_out;
	fwdsel_t fwd_a, fwd_b;
	logic halt_r, mem_block;

	// operand mux behind the forwarding selects
	function automatic word_t fwd_mux(fwdsel_t sel, word_t rf_val);
		case (sel)
			FWD_EX_MEM: return ex_mem_q.result;
			FWD_MEM_WB: return mem_wb_q.wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign if_id_d = '{instr: instr, npc: npc};
	pipe_reg #(.payload_t(if_id_t)) if_id_reg (.CLK, .rst, .en(enable_IF_ID),
		.flush(flush_IF_ID), .d(if_id_d), .q(if_id_q));

	// decode
	assign ir = if_id_q.instr;
	assign opcode_IF_ID = opcode_t'(ir[31:26]);
	assign func_IF_ID = funct_t'(ir[5:0]);
	assign Rs_IF_ID = ir[25:21];
	assign Rt_IF_ID = ir[20:16];
	assign imm_sext = {{16{ir[15]}}, ir[15:0]};
	assign jmp_addr = {if_id_q.npc[31:28], ir[25:0], 2'b00};
	// no forwarding for jr, the program spaces it from the producer
	assign jr_addr = rdat1;

	register_file rf (.CLK, .rst, .wen(mem_wb_q.reg_wen), .wsel(mem_wb_q.rd),
		.rsel1(ir[25:21]), .rsel2(ir[20:16]), .wdat(mem_wb_q.wb_val), .rdat1, .rdat2);

	always_comb begin
		id_ex_d = '0;
		id_ex_d.opcode = opcode_IF_ID;
		id_ex_d.rs = ir[25:21];
		id_ex_d.rt = ir[20:16];
		id_ex_d.rd = ir[20:16];
		id_ex_d.rdat1 = rdat1;
		id_ex_d.rdat2 = rdat2;
		id_ex_d.imm = imm_sext;
		id_ex_d.npc = if_id_q.npc;
		id_ex_d.br_addr = if_id_q.npc + {imm_sext[29:0], 2'b00};
		case (opcode_IF_ID)
			RTYPE: begin
				id_ex_d.rd = ir[15:11];
				id_ex_d.reg_wen = 1'b1;
				case (func_IF_ID)
					ADDU: id_ex_d.aluop = ALU_ADD;
					SUBU: id_ex_d.aluop = ALU_SUB;
					AND: id_ex_d.aluop = ALU_AND;
					OR: id_ex_d.aluop = ALU_OR;
					SLT: id_ex_d.aluop = ALU_SLT;
					// jr and unsupported functs write nothing
					default: id_ex_d.reg_wen = 1'b0;
				endcase
			end
			ADDIU: begin
				id_ex_d.alu_src_imm = 1'b1;
				id_ex_d.reg_wen = 1'b1;
			end
			ORI: begin
				id_ex_d.imm = {16'h0000, ir[15:0]};
				id_ex_d.aluop = ALU_OR;
				id_ex_d.alu_src_imm = 1'b1;
				id_ex_d.reg_wen = 1'b1;
			end
			LUI: begin
				// rs field is zero, so or with the shifted immediate
				id_ex_d.imm = {ir[15:0], 16'h0000};
				id_ex_d.aluop = ALU_OR;
				id_ex_d.alu_src_imm = 1'b1;
				id_ex_d.reg_wen = 1'b1;
			end
			LW: begin
				id_ex_d.alu_src_imm = 1'b1;
				id_ex_d.reg_wen = 1'b1;
				id_ex_d.dren = 1'b1;
			end
			SW: begin
				id_ex_d.alu_src_imm = 1'b1;
				id_ex_d.dwen = 1'b1;
			end
			JAL: begin
				id_ex_d.rd = 5'd31;
				id_ex_d.reg_wen = 1'b1;
			end
			HALT: id_ex_d.halt = 1'b1;
			default: ;
		endcase
	end

	pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (.CLK, .rst, .en(enable_ID_EX),
		.flush(flush_ID_EX), .d(id_ex_d), .q(id_ex_q));

	assign Rt_ID_EX = id_ex_q.rt;
	assign dREN_ID_EX = id_ex_q.dren;

	// execute
	forwarding_unit fwd (.rs_ID_EX(id_ex_q.rs), .rt_ID_EX(id_ex_q.rt),
		.rd_EX_MEM(ex_mem_q.rd), .rd_MEM_WB(mem_wb_q.rd), .wen_EX_MEM(ex_mem_q.reg_wen),
		.wen_MEM_WB(mem_wb_q.reg_wen), .fwd_a, .fwd_b);

	assign op_a = fwd_mux(fwd_a, id_ex_q.rdat1);
	assign op_b = fwd_mux(fwd_b, id_ex_q.rdat2);
	assign alu_b = id_ex_q.alu_src_imm ? id_ex_q.imm : op_b;

	always_comb begin
		case (id_ex_q.aluop)
			ALU_SUB: alu_out = op_a - alu_b;
			ALU_AND: alu_out = op_a & alu_b;
			ALU_OR: alu_out = op_a | alu_b;
			ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
			default: alu_out = op_a + alu_b;
		endcase
	end

	always_comb begin
		ex_mem_d.opcode = id_ex_q.opcode;
		// branch compare on the forwarded register operands
		ex_mem_d.zero = (op_a == op_b);
		// link address takes the alu result slot for jal
		ex_mem_d.result = (id_ex_q.opcode == JAL) ? id_ex_q.npc : alu_out;
		ex_mem_d.wdata = op_b;
		ex_mem_d.br_addr = id_ex_q.br_addr;
		ex_mem_d.dren = id_ex_q.dren;
		ex_mem_d.dwen = id_ex_q.dwen;
		ex_mem_d.rd = id_ex_q.rd;
		ex_mem_d.reg_wen = id_ex_q.reg_wen;
		ex_mem_d.halt = id_ex_q.halt;
	end

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (.CLK, .rst, .en(enable_EX_MEM),
		.flush(flush_EX_MEM), .d(ex_mem_d), .q(ex_mem_q));

	// memory
	assign opcode_EX_MEM = ex_mem_q.opcode;
	assign zero_EX_MEM = ex_mem_q.zero;
	assign br_addr = ex_mem_q.br_addr;
	assign mem_addr = ex_mem_q.result;
	assign mem_wdata = ex_mem_q.wdata;
	// anything behind a committed halt stays off the data bus
	assign mem_block = mem_wb_q.halt | halt_r;
	assign mem_ren = ex_mem_q.dren & ~mem_block;
	assign mem_wen = ex_mem_q.dwen & ~mem_block;

	assign mem_wb_d = '{wb_val: ex_mem_q.dren ? load_data : ex_mem_q.result,
		rd: ex_mem_q.rd, reg_wen: ex_mem_q.reg_wen, halt: ex_mem_q.halt};

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (.CLK, .rst, .en(enable_MEM_WB),
		.flush(flush_MEM_WB), .d(mem_wb_d), .q(mem_wb_q));

	// sticky halt once the halt instruction retires
	always_ff @(posedge CLK) begin
		if (rst)
			halt_r <= 1'b0;
		else if (mem_wb_q.halt)
			halt_r <= 1'b1;
	end

	assign halt = halt_r;

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module fetch_unit (
	input logic CLK,
	input logic rst,
	input cpu_types_pkg::pcsel_t pc_src,
	input logic enable_pc,
	input cpu_types_pkg::word_t br_addr,
	input cpu_types_pkg::word_t jmp_addr,
	input cpu_types_pkg::word_t jr_addr,
	input logic halt,
	input cpu_types_pkg::word_t i_dat_rd,
	input logic i_ack,
	output logic i_cyc,
	output logic i_stb,
	output cpu_types_pkg::word_t i_adr,
	output cpu_types_pkg::word_t instr,
	output cpu_types_pkg::word_t npc,
	output logic ihit
);
	import cpu_types_pkg::*;

	word_t pc, pc_next, buf_instr;
	logic buf_valid, busy;

	// one read in flight per pc value
	assign i_cyc = busy;
	assign i_stb = busy;
	assign i_adr = pc;
	assign npc = pc + `CPU_WORD_BYTES;

	// word straight off the bus, or the one held across a stall
	assign ihit = buf_valid | (busy & i_ack);
	assign instr = buf_valid ? buf_instr : i_dat_rd;

	always_comb begin
		case (pc_src)
			SEL_LOAD_BR_ADDR: pc_next = br_addr;
			SEL_LOAD_JMP_ADDR: pc_next = jmp_addr;
			SEL_LOAD_JR_ADDR: pc_next = jr_addr;
			default: pc_next = npc;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
			busy <= 1'b1;
			buf_valid <= 1'b0;
		end else if (enable_pc) begin
			// instruction consumed, go fetch the next one unless halted
			pc <= pc_next;
			buf_valid <= 1'b0;
			busy <= ~halt;
		end else if (busy & i_ack) begin
			// pipeline is stalled, park the word
			busy <= 1'b0;
			buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (busy & i_ack)
			buf_instr <= i_dat_rd;
	end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
	input cpu_types_pkg::opcode_t opcode_IF_ID,
	input cpu_types_pkg::opcode_t opcode_EX_MEM,
	input cpu_types_pkg::funct_t func_IF_ID,
	input cpu_types_pkg::regbits_t Rs_IF_ID,
	input cpu_types_pkg::regbits_t Rt_IF_ID,
	input cpu_types_pkg::regbits_t Rt_ID_EX,
	input logic dREN_ID_EX,
	input logic zero_EX_MEM,
	input logic ihit,
	input logic dmem_wait,
	output cpu_types_pkg::pcsel_t PCSrc,
	output logic enable_IF_ID,
	output logic enable_ID_EX,
	output logic enable_EX_MEM,
	output logic enable_MEM_WB,
	output logic flush_IF_ID,
	output logic flush_ID_EX,
	output logic flush_EX_MEM,
	output logic flush_MEM_WB,
	output logic enable_pc
);
	import cpu_types_pkg::*;

	logic control_haz, load_haz, jump_haz, jr_haz, advance;

	// beq equal or bne not equal, resolved in mem
	assign control_haz = ((opcode_EX_MEM == BEQ) & zero_EX_MEM) |
		((opcode_EX_MEM == BNE) & ~zero_EX_MEM);
	// load result wanted by the very next instruction
	assign load_haz = dREN_ID_EX & ((Rt_ID_EX == Rs_IF_ID) | (Rt_ID_EX == Rt_IF_ID));
	assign jump_haz = (opcode_IF_ID == J) | (opcode_IF_ID == JAL);
	assign jr_haz = (opcode_IF_ID == RTYPE) & (func_IF_ID == JR);
	// nothing moves without an instruction or during a data access
	assign advance = ihit & ~dmem_wait;

	always_comb begin
		PCSrc = SEL_LOAD_NXT_INSTR;
		enable_IF_ID = advance;
		enable_ID_EX = advance;
		enable_EX_MEM = advance;
		enable_MEM_WB = advance;
		enable_pc = advance;
		flush_IF_ID = 1'b0;
		flush_ID_EX = 1'b0;
		flush_EX_MEM = 1'b0;
		flush_MEM_WB = 1'b0;
		if (advance) begin
			if (control_haz) begin
				// squash the three younger instructions
				PCSrc = SEL_LOAD_BR_ADDR;
				flush_IF_ID = 1'b1;
				flush_ID_EX = 1'b1;
				flush_EX_MEM = 1'b1;
			end else if (load_haz) begin
				// hold pc and if/id, bubble into ex
				enable_pc = 1'b0;
				enable_IF_ID = 1'b0;
				flush_ID_EX = 1'b1;
			end else if (jump_haz) begin
				PCSrc = SEL_LOAD_JMP_ADDR;
				flush_IF_ID = 1'b1;
			end else if (jr_haz) begin
				// target is the register file value read in decode
				PCSrc = SEL_LOAD_JR_ADDR;
				flush_IF_ID = 1'b1;
			end
		end
	end

endmodule

//--- rtl/memory_port.sv
`timescale 1ns/1ns

module memory_port (
	input logic CLK,
	input logic rst,
	input logic mem_ren,
	input logic mem_wen,
	input cpu_types_pkg::word_t mem_addr,
	input cpu_types_pkg::word_t mem_wdata,
	input cpu_types_pkg::word_t d_dat_rd,
	input logic d_ack,
	output logic d_cyc,
	output logic d_stb,
	output logic d_we,
	output cpu_types_pkg::word_t d_adr,
	output cpu_types_pkg::word_t d_dat_wr,
	output cpu_types_pkg::word_t load_data,
	output logic dmem_wait
);
	import cpu_types_pkg::*;

	word_t adr_r, wdat_r, data_r;
	logic we_r, done, req, served;

	assign req = mem_ren | mem_wen;
	// request already acknowledged while the pipeline was held
	assign served = done & (adr_r == mem_addr) & (we_r == mem_wen) & (wdat_r == mem_wdata);

	assign d_cyc = req & ~served;
	assign d_stb = d_cyc;
	assign d_we = d_cyc & mem_wen;
	assign d_adr = mem_addr;
	assign d_dat_wr = mem_wdata;

	// ack releases the stall in the same cycle
	assign dmem_wait = d_cyc & ~d_ack;
	assign load_data = d_ack ? d_dat_rd : data_r;

	always_ff @(posedge CLK) begin
		if (rst)
			done <= 1'b0;
		else
			done <= (d_cyc & d_ack) | served;
	end

	// copy of the served request and its read data
	always_ff @(posedge CLK) begin
		if (d_cyc & d_ack) begin
			adr_r <= mem_addr;
			we_r <= mem_wen;
			wdat_r <= mem_wdata;
			data_r <= d_dat_rd;
		end
	end

endmodule

//--- rtl/pipeline_core.sv
`timescale 1ns/1ns

module pipeline_core (
	input logic CLK,
	input logic rst,
	output logic i_cyc,
	output logic i_stb,
	output cpu_types_pkg::word_t i_adr,
	input cpu_types_pkg::word_t i_dat_rd,
	input logic i_ack,
	output logic d_cyc,
	output logic d_stb,
	output logic d_we,
	output cpu_types_pkg::word_t d_adr,
	output cpu_types_pkg::word_t d_dat_wr,
	input cpu_types_pkg::word_t d_dat_rd,
	input logic d_ack,
	output logic halt
);
	import cpu_types_pkg::*;

	// fetch to datapath and hazard control
	word_t instr, npc, br_addr, jmp_addr, jr_addr;
	logic ihit, enable_pc;
	pcsel_t PCSrc;

	// stage register control
	logic enable_IF_ID, enable_ID_EX, enable_EX_MEM, enable_MEM_WB;
	logic flush_IF_ID, flush_ID_EX, flush_EX_MEM, flush_MEM_WB;

	// hazard inputs from the stage registers
	opcode_t opcode_IF_ID, opcode_EX_MEM;
	funct_t func_IF_ID;
	regbits_t Rs_IF_ID, Rt_IF_ID, Rt_ID_EX;
	logic dREN_ID_EX, zero_EX_MEM;

	// data memory request and response
	word_t mem_addr, mem_wdata, load_data;
	logic mem_ren, mem_wen, dmem_wait;

	fetch_unit u_fetch (.pc_src(PCSrc), .*);

	datapath u_datapath (.*);

	hazard_unit u_hazard (.*);

	memory_port u_memory_port (.*);

endmodule

//--- dv/wb_mem_model.sv
`timescale 1ns/1ns

module wb_mem_model (
	input logic CLK,
	input logic rst,
	input logic [3:0] max_wait,
	input logic cyc,
	input logic stb,
	input logic we,
	input cpu_types_pkg::word_t adr,
	input cpu_types_pkg::word_t dat_wr,
	output cpu_types_pkg::word_t dat_rd,
	output logic ack
);
	import cpu_types_pkg::*;

	// word array, preloaded from the testbench
	word_t mem [256];
	integer seed;
	int waits;
	logic pending;

	initial begin
		seed = 32'hc040_eda7;
		dat_rd = '0;
		ack = 1'b0;
		pending = 1'b0;
		waits = 0;
	end

	// slave side changes on the falling edge, the core samples on the rising one
	always @(negedge CLK) begin
		if (rst) begin
			ack = 1'b0;
			pending = 1'b0;
		end else if (ack) begin
			// one ack ends the classic cycle
			ack = 1'b0;
		end else if (cyc && stb) begin
			// new request, draw its wait states
			if (!pending) begin
				pending = 1'b1;
				waits = $unsigned($random(seed)) % (max_wait + 1);
			end
			if (waits == 0) begin
				if (we)
					mem[adr[9:2]] = dat_wr;
				dat_rd = mem[adr[9:2]];
				ack = 1'b1;
				pending = 1'b0;
			end else begin
				waits--;
			end
		end else begin
			pending = 1'b0;
		end
	end

endmodule

//--- dv/pipeline_core_tb.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module pipeline_core_tb;
	import cpu_types_pkg::*;

	localparam logic [3:0] max_wait = 4'd3;
	// fetch and data access at worst wait, plus a flush or a stall
	localparam int cycles_per_instr = 8;

	logic CLK = 1'b0;
	logic rst;
	logic i_cyc, i_stb, i_ack, d_cyc, d_stb, d_we, d_ack, halt;
	word_t i_adr, i_dat_rd, d_adr, d_dat_wr, d_dat_rd;

	word_t prog [256];
	word_t exp_adr [$];
	word_t exp_dat [$];
	int n_instr;
	int timeout_ns = 0;
	int stores_seen = 0;
	logic halt_seen = 1'b0;
	// open bus cycles seen at the previous rising edge
	logic i_held, d_held;
	word_t i_held_adr, d_held_adr;

	pipeline_core DUT (.CLK(CLK), .rst(rst), .i_cyc(i_cyc), .i_stb(i_stb), .i_adr(i_adr),
		.i_dat_rd(i_dat_rd), .i_ack(i_ack), .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we),
		.d_adr(d_adr), .d_dat_wr(d_dat_wr), .d_dat_rd(d_dat_rd), .d_ack(d_ack), .halt(halt));

	// instruction side never writes
	wb_mem_model imem (.CLK(CLK), .rst(rst), .max_wait(max_wait), .cyc(i_cyc), .stb(i_stb),
		.we(1'b0), .adr(i_adr), .dat_wr('0), .dat_rd(i_dat_rd), .ack(i_ack));

	wb_mem_model dmem (.CLK(CLK), .rst(rst), .max_wait(max_wait), .cyc(d_cyc), .stb(d_stb),
		.we(d_we), .adr(d_adr), .dat_wr(d_dat_wr), .dat_rd(d_dat_rd), .ack(d_ack));

	always #10 CLK = ~CLK;

	function automatic word_t encode_rtype(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd);
		return {RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic word_t encode_itype(opcode_t op, regbits_t rs, regbits_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_jtype(opcode_t op, logic [25:0] target);
		return {op, target};
	endfunction

	// initial data memory contents mix every address bit
	function automatic word_t fill_word(word_t adr);
		return (adr * 32'h0001_0001) ^ 32'hc3a5_5a3c;
	endfunction

	task automatic load_program();
		int i;
		for (i = 0; i < 256; i++)
			prog[i] = '0;
		// base pointer and alu operands
		prog[0] = encode_itype(ADDIU, 0, 10, 16'h0100);
		prog[1] = encode_itype(ADDIU, 0, 1, 16'h0007);
		prog[2] = encode_itype(ADDIU, 0, 2, 16'hfffd);
		// back to back users, ex/mem and mem/wb forwarding
		prog[3] = encode_rtype(ADDU, 1, 2, 3);
		prog[4] = encode_rtype(SUBU, 3, 1, 4);
		prog[5] = encode_rtype(AND, 3, 1, 5);
		prog[6] = encode_rtype(OR, 4, 2, 6);
		prog[7] = encode_rtype(SLT, 4, 1, 7);
		prog[8] = encode_itype(SW, 10, 3, 16'd0);
		prog[9] = encode_itype(SW, 10, 4, 16'd4);
		prog[10] = encode_itype(SW, 10, 5, 16'd8);
		prog[11] = encode_itype(SW, 10, 6, 16'd12);
		prog[12] = encode_itype(SW, 10, 7, 16'd16);
		prog[13] = encode_itype(LUI, 0, 8, 16'h1234);
		prog[14] = encode_itype(ORI, 8, 8, 16'h5678);
		prog[15] = encode_itype(SW, 10, 8, 16'd20);
		// load-use on rs, then on the store data
		prog[16] = encode_itype(LW, 10, 9, 16'd64);
		prog[17] = encode_rtype(ADDU, 9, 1, 11);
		prog[18] = encode_itype(SW, 10, 11, 16'd24);
		prog[19] = encode_itype(LW, 10, 12, 16'd68);
		prog[20] = encode_itype(SW, 10, 12, 16'd28);
		// taken beq, both stores behind it squashed
		prog[21] = encode_itype(BEQ, 1, 1, 16'd2);
		prog[22] = encode_itype(SW, 10, 1, 16'd32);
		prog[23] = encode_itype(SW, 10, 2, 16'd36);
		prog[24] = encode_itype(BNE, 1, 1, 16'd1);
		prog[25] = encode_itype(SW, 10, 1, 16'd32);
		prog[26] = encode_itype(BEQ, 1, 2, 16'd1);
		prog[27] = encode_itype(SW, 10, 2, 16'd36);
		prog[28] = encode_itype(BNE, 3, 4, 16'd2);
		prog[29] = encode_itype(SW, 10, 3, 16'd40);
		prog[30] = encode_itype(SW, 10, 4, 16'd44);
		prog[31] = encode_itype(SW, 10, 5, 16'd40);
		// call, return through r31, then a plain jump
		prog[32] = encode_jtype(JAL, 26'd40);
		prog[33] = encode_itype(SW, 10, 31, 16'd48);
		prog[34] = encode_jtype(J, 26'd45);
		prog[35] = encode_itype(SW, 10, 14, 16'd56);
		prog[40] = encode_itype(ADDIU, 0, 13, 16'h0055);
		prog[41] = encode_itype(SW, 10, 13, 16'd52);
		prog[42] = encode_itype(ADDIU, 13, 14, 16'd1);
		prog[43] = encode_rtype(JR, 31, 0, 0);
		prog[44] = encode_itype(SW, 10, 1, 16'd60);
		prog[45] = encode_itype(SW, 10, 14, 16'd60);
		// short loop closed by a backward bne
		prog[46] = encode_itype(ADDIU, 0, 16, 16'd3);
		prog[47] = encode_itype(ADDIU, 0, 17, 16'd0);
		prog[48] = encode_rtype(ADDU, 17, 16, 17);
		prog[49] = encode_itype(ADDIU, 16, 16, 16'hffff);
		prog[50] = encode_itype(BNE, 16, 0, 16'hfffd);
		prog[51] = encode_itype(SW, 10, 17, 16'd80);
		prog[52] = encode_itype(SW, 10, 16, 16'd84);
		prog[53] = {HALT, 26'd0};
		// must never reach the data bus
		prog[54] = encode_itype(SW, 10, 1, 16'd88);
		for (i = 0; i < 256; i++) begin
			imem.mem[i] = prog[i];
			dmem.mem[i] = fill_word(i * 4);
		end
	endtask

	// architectural model of the program that fills the expected store list
	function automatic int run_reference();
		word_t regs [32];
		word_t dm [256];
		word_t pc, ir, a, b, imm, ea, npc, val;
		regbits_t dest;
		logic wen;
		int count, i;
		for (i = 0; i < 32; i++)
			regs[i] = '0;
		for (i = 0; i < 256; i++)
			dm[i] = fill_word(i * 4);
		pc = `CPU_RESET_PC;
		count = 0;
		while (count < 4096) begin
			ir = prog[pc[9:2]];
			a = regs[ir[25:21]];
			b = regs[ir[20:16]];
			imm = {{16{ir[15]}}, ir[15:0]};
			ea = a + imm;
			npc = pc + `CPU_WORD_BYTES;
			dest = ir[20:16];
			wen = 1'b0;
			val = '0;
			count++;
			case (opcode_t'(ir[31:26]))
				RTYPE: begin
					dest = ir[15:11];
					wen = 1'b1;
					case (funct_t'(ir[5:0]))
						ADDU: val = a + b;
						SUBU: val = a - b;
						AND: val = a & b;
						OR: val = a | b;
						SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						JR: begin
							wen = 1'b0;
							npc = a;
						end
						default: wen = 1'b0;
					endcase
				end
				ADDIU: begin
					wen = 1'b1;
					val = ea;
				end
				ORI: begin
					wen = 1'b1;
					val = a | {16'h0000, ir[15:0]};
				end
				LUI: begin
					wen = 1'b1;
					val = {ir[15:0], 16'h0000};
				end
				LW: begin
					wen = 1'b1;
					val = dm[ea[9:2]];
				end
				SW: begin
					dm[ea[9:2]] = b;
					exp_adr.push_back(ea);
					exp_dat.push_back(b);
				end
				BEQ: if (a == b) npc = npc + {imm[29:0], 2'b00};
				BNE: if (a != b) npc = npc + {imm[29:0], 2'b00};
				J: npc = {npc[31:28], ir[25:0], 2'b00};
				JAL: begin
					wen = 1'b1;
					dest = 5'd31;
					val = npc;
					npc = {npc[31:28], ir[25:0], 2'b00};
				end
				HALT: return count;
				default: ;
			endcase
			if (wen && dest != '0)
				regs[dest] = val;
			pc = npc;
		end
		return count;
	endfunction

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_store(word_t adr, word_t dat);
		if (stores_seen >= exp_adr.size())
			abort_run($sformatf("[ERROR] %0t: extra store of %h to %h, only %0d expected",
				$time, dat, adr, exp_adr.size()));
		else if (adr !== exp_adr[stores_seen] || dat !== exp_dat[stores_seen])
			abort_run($sformatf("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, stores_seen, dat, adr, exp_dat[stores_seen], exp_adr[stores_seen]));
	endtask

	// low until every expected store is on the bus, then high once it has risen
	task automatic check_halt(logic got, logic exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: halt is %b after %0d of %0d stores, expected %b",
				$time, got, stores_seen, exp_adr.size(), exp));
	endtask

	// an open classic cycle keeps cyc, stb and the address until its ack
	task automatic check_bus_hold(string bus, logic cyc, logic stb, word_t adr,
		word_t held_adr);
		if (cyc !== 1'b1 || stb !== 1'b1)
			abort_run($sformatf("[ERROR] %0t: %s bus cyc %b stb %b before ack, expected 1 1",
				$time, bus, cyc, stb));
		else if (adr !== held_adr)
			abort_run($sformatf("[ERROR] %0t: %s bus address %h before ack, expected %h",
				$time, bus, adr, held_adr));
	endtask

	// bus monitor samples on the rising edge where the core takes ack
	always @(posedge CLK) begin
		if (rst) begin
			i_held = 1'b0;
			d_held = 1'b0;
		end else begin
			if (i_held)
				check_bus_hold("instruction", i_cyc, i_stb, i_adr, i_held_adr);
			if (d_held)
				check_bus_hold("data", d_cyc, d_stb, d_adr, d_held_adr);
			if (d_cyc && d_stb && d_we && d_ack) begin
				if (halt_seen)
					abort_run("a data write completed after halt");
				else begin
					check_store(d_adr, d_dat_wr);
					stores_seen++;
				end
			end
			if (stores_seen < exp_adr.size())
				check_halt(halt, 1'b0);
			else if (halt_seen)
				check_halt(halt, 1'b1);
			if (halt === 1'b1)
				halt_seen = 1'b1;
			if (halt_seen && d_cyc)
				abort_run("a data bus cycle started after halt");
			i_held = i_cyc & ~i_ack;
			i_held_adr = i_adr;
			d_held = d_cyc & ~d_ack;
			d_held_adr = d_adr;
		end
	end

	initial begin
		rst = 1'b1;
		load_program();
		n_instr = run_reference();
		timeout_ns = (n_instr * cycles_per_instr * (max_wait + 1) + 200) * 20;
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		wait (halt_seen);
		// give a stray write behind the halt time to show up
		repeat (20) @(posedge CLK);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// watchdog sized from the reference instruction count
	initial begin
		wait (timeout_ns > 0);
		#(timeout_ns);
		abort_run($sformatf("timeout, halt not reached within %0d ns", timeout_ns));
	end

endmodule

//--- pipeline_core.f
+incdir+common
common/cpu_types_pkg.sv
rtl/pipe_reg.sv
datapath/register_file.sv
datapath/forwarding_unit.sv
datapath/datapath.sv
rtl/fetch_unit.sv
rtl/hazard_unit.sv
rtl/memory_port.sv
rtl/pipeline_core.sv
dv/wb_mem_model.sv
dv/pipeline_core_tb.sv
